// ==== list.f ====
+incdir+common
common/jvm_pkg.sv
rtl/bytecode_decoder.sv
rtl/int_alu.sv
storage/eval_stack.sv
storage/local_var_array.sv
rtl/exec_control.sv
rtl/jvm_exec_top.sv
verification/jvm_exec_assertions.sv
verification/jvm_exec_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= jvm_exec_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/jvm_exec_tb.sv ====
`timescale 1ns/1ps
`include "jvm_consts.svh"

module jvm_exec_tb;
    import jvm_pkg::*;

    logic    clk = 1'b0;
    logic    rst_n = 1'b0;
    byte_t   op_code = `OP_NOP;
    byte_t   arg1 = '0;
    byte_t   arg2 = '0;
    logic    op_done;
    offset_t offset;
    word_t   tos;
    depth_t  stack_depth;

    word_t   model_stack [$];                  // back of the queue is the top
    word_t   model_locals [`JVM_LVA_SIZE];

    always #2 clk = ~clk;                      // 4 ns period

    jvm_exec_top jvm_exec_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_code     (op_code),
        .arg1        (arg1),
        .arg2        (arg2),
        .op_done     (op_done),
        .offset      (offset),
        .tos         (tos),
        .stack_depth (stack_depth)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected)
            report_failure($sformatf("** Error %s: expected %h, got %h", name, expected, actual));
    endtask

    task automatic check_offset(input string name, input offset_t expected,
                                input offset_t actual);
        if (actual !== expected)
            report_failure($sformatf("** Error %s: expected %h, got %h", name, expected, actual));
    endtask

    task automatic check_depth(input string name, input depth_t expected, input depth_t actual);
        if (actual !== expected)
            report_failure($sformatf("** Error %s: expected %0d, got %0d", name, expected,
                                     actual));
    endtask

    task automatic check_assertions();
        if (jvm_exec_top_inst.jvm_exec_assertions_inst.fail_count != 0)
            report_failure("a bound assertion on the top level failed");
    endtask

    // reference stack drops a push when full and pops 0 when empty
    function automatic void model_push(input word_t value);
        if (model_stack.size() < `JVM_STACK_DEPTH)
            model_stack.push_back(value);
    endfunction

    function automatic word_t model_pop();
        if (model_stack.size() == 0)
            return '0;
        return model_stack.pop_back();
    endfunction

    function automatic word_t model_top();
        if (model_stack.size() == 0)
            return '0;
        return model_stack[model_stack.size() - 1];
    endfunction

    function automatic word_t alu_expect(input byte_t op, input word_t a, input word_t b);
        logic signed [31:0] sa;
        sa = a;
        case (op)
            `OP_ISUB: return a - b;
            `OP_IMUL: return a * b;                         // wraps to the low word
            `OP_ISHL: return a << b[4:0];
            `OP_ISHR: return sa >>> b[4:0];
            `OP_IAND: return a & b;
            `OP_IOR:  return a | b;
            `OP_IXOR: return a ^ b;
            default:  return a + b;
        endcase
    endfunction

    // JVM order of both branch groups is eq, ne, lt, ge, gt, le
    function automatic logic branch_expect(input byte_t op, input word_t a, input word_t b);
        int                 sel;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        if (op >= `OP_IF_ICMPEQ) begin
            sel = int'(op) - int'(`OP_IF_ICMPEQ);
            sb  = b;
        end else begin
            sel = int'(op) - int'(`OP_IFEQ);
            sb  = '0;
        end
        case (sel)
            0:       return sa == sb;
            1:       return sa != sb;
            2:       return sa < sb;
            3:       return sa >= sb;
            4:       return sa > sb;
            default: return sa <= sb;
        endcase
    endfunction

    task automatic run_op(input byte_t op, input byte_t a1, input byte_t a2);
        int cycles;
        op_code <= op;
        arg1    <= a1;
        arg2    <= a2;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > 50)
                report_failure($sformatf("timeout waiting for op_done of opcode %h", op));
        end while (!op_done);
    endtask

    // runs one instruction against a model that already holds the state after it
    task automatic exec_op(input string name, input byte_t op, input byte_t a1,
                           input byte_t a2, input int exp_offset);
        run_op(op, a1, a2);
        check_offset({name, " offset"}, offset_t'(exp_offset), offset);
        check_word({name, " tos"}, model_top(), tos);
        check_depth({name, " depth"}, depth_t'(model_stack.size()), stack_depth);
        check_assertions();
    endtask

    task automatic hold_idle_op(input byte_t op, input int cycles);
        op_code <= op;
        arg1    <= '0;
        arg2    <= '0;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            if (op_done)
                report_failure($sformatf("op_done pulsed while idle opcode %h was held", op));
        end
    endtask

    task automatic push_value(input logic [15:0] value);
        model_push({{16{value[15]}}, value});
        exec_op($sformatf("sipush %h", value), `OP_SIPUSH, value[15:8], value[7:0], 3);
    endtask

    task automatic push_byte(input byte_t value);
        model_push({{24{value[7]}}, value});
        exec_op($sformatf("bipush %h", value), `OP_BIPUSH, value, 8'h00, 2);
    endtask

    task automatic drain_stack();
        while (model_stack.size() > 0) begin
            model_locals[15] = model_pop();
            exec_op("drain istore 15", `OP_ISTORE, 8'h0f, 8'h00, 2);
        end
    endtask

    task automatic test_const_push();
        for (int k = -1; k <= 5; k++) begin
            model_push(word_t'(k));
            exec_op($sformatf("iconst %0d", k), byte_t'(int'(`OP_ICONST_0) + k),
                    8'h00, 8'h00, 1);
        end
        push_byte(8'h80);
        push_value(16'h1234);
    endtask

    task automatic test_alu();
        byte_t       ops [8] = '{`OP_IADD, `OP_ISUB, `OP_IMUL, `OP_ISHL,
                                 `OP_ISHR, `OP_IAND, `OP_IOR, `OP_IXOR};
        logic [15:0] ra;
        logic [15:0] rb;
        word_t       a;
        word_t       b;
        drain_stack();
        for (int i = 0; i < 8; i++) begin
            ra = 16'($urandom);
            rb = 16'($urandom);
            push_value(ra);
            push_value(rb);
            b = model_pop();
            a = model_pop();
            model_push(alu_expect(ops[i], a, b));
            exec_op($sformatf("alu %h", ops[i]), ops[i], 8'h00, 8'h00, 1);
        end
    endtask

    task automatic test_locals();
        logic [15:0] v1;
        logic [15:0] v2;
        drain_stack();
        model_push(model_locals[7]);                        // never written
        exec_op("iload 7 unwritten", `OP_ILOAD, 8'h07, 8'h00, 2);
        model_push(model_locals[0]);
        exec_op("iload_0 unwritten", `OP_ILOAD_0, 8'h00, 8'h00, 1);
        v1 = 16'($urandom);
        v2 = 16'($urandom);
        push_value(v1);
        model_locals[9] = model_pop();
        exec_op("istore 9", `OP_ISTORE, 8'h09, 8'h00, 2);
        push_value(v2);
        model_locals[2] = model_pop();
        exec_op("istore_2", `OP_ISTORE_2, 8'h00, 8'h00, 1);
        model_push(model_locals[9]);
        exec_op("iload 9", `OP_ILOAD, 8'h09, 8'h00, 2);
        model_push(model_locals[2]);
        exec_op("iload_2", `OP_ILOAD_2, 8'h00, 8'h00, 1);
        model_push(model_locals[9]);                        // low nibble of 0x19
        exec_op("iload 0x19", `OP_ILOAD, 8'h19, 8'h00, 2);
    endtask

    // value sets give each compare type a taken and a not taken case
    task automatic test_branches();
        byte_t       one_vals [3] = '{8'hfb, 8'h00, 8'h07};
        byte_t       lhs_vals [3] = '{8'hfb, 8'h03, 8'h03};
        byte_t       rhs_vals [3] = '{8'h03, 8'h03, 8'hfb};
        byte_t       op;
        logic [15:0] target;
        word_t       a;
        word_t       b;
        logic        taken;
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 3; j++) begin
                op     = byte_t'(int'(`OP_IFEQ) + i);
                target = 16'($urandom);
                push_byte(one_vals[j]);
                a      = model_pop();
                taken  = branch_expect(op, a, '0);
                exec_op($sformatf("if %h on %h", op, one_vals[j]), op, target[15:8],
                        target[7:0], taken ? int'(target) : 3);
            end
        end
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 3; j++) begin
                op     = byte_t'(int'(`OP_IF_ICMPEQ) + i);
                target = 16'($urandom);
                push_byte(lhs_vals[j]);
                push_byte(rhs_vals[j]);
                b      = model_pop();
                a      = model_pop();
                taken  = branch_expect(op, a, b);
                exec_op($sformatf("if_icmp %h on %h %h", op, lhs_vals[j], rhs_vals[j]), op,
                        target[15:8], target[7:0], taken ? int'(target) : 3);
            end
        end
    endtask

    task automatic test_goto_idle();
        push_byte(8'h2a);
        exec_op("goto backward", `OP_GOTO, 8'hff, 8'hf0, 'hfff0);
        hold_idle_op(`OP_NOP, 20);
        hold_idle_op(`OP_RETURN, 10);
        model_push(word_t'(4));
        exec_op("iconst_4 after idle", `OP_ICONST_4, 8'h00, 8'h00, 1);
    endtask

    task automatic test_stack_limits();
        word_t       a;
        word_t       b;
        word_t       sixteenth;
        logic [15:0] v;
        drain_stack();
        a = model_pop();
        exec_op("ifeq on empty stack", `OP_IFEQ, 8'h00, 8'h10,
                branch_expect(`OP_IFEQ, a, '0) ? 16 : 3);
        b = model_pop();
        a = model_pop();
        model_push(alu_expect(`OP_IADD, a, b));              // both pops read 0
        exec_op("iadd on empty stack", `OP_IADD, 8'h00, 8'h00, 1);
        drain_stack();
        sixteenth = '0;
        for (int i = 0; i < 17; i++) begin
            v = 16'($urandom);
            if (i == 15)
                sixteenth = {{16{v[15]}}, v};
            push_value(v);                                  // last one is dropped
        end
        check_word("tos after 17 pushes", sixteenth, tos);
        check_depth("depth after 17 pushes", depth_t'(`JVM_STACK_DEPTH), stack_depth);
    endtask

    initial begin
        void'($urandom(1));
        for (int i = 0; i < `JVM_LVA_SIZE; i++)
            model_locals[i] = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        test_const_push();
        test_alu();
        test_locals();
        test_branches();
        test_goto_idle();
        test_stack_limits();
        check_assertions();
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== verification/jvm_exec_assertions.sv ====
`timescale 1ns/1ps
`include "jvm_consts.svh"

module jvm_exec_assertions (
    input logic             clk,
    input logic             rst_n,
    input logic             op_done,
    input jvm_pkg::offset_t offset,
    input jvm_pkg::depth_t  stack_depth
);
    import jvm_pkg::*;

    int unsigned fail_count = 0;    // read by the testbench

    // completion is a single-cycle strobe
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        op_done |=> !op_done)
        else begin
            $error("op_done stayed high for more than one cycle");
            fail_count++;
        end

    a_depth_max: assert property (@(posedge clk) disable iff (!rst_n)
        stack_depth <= depth_t'(`JVM_STACK_DEPTH))
        else begin
            $error("stack_depth above the stack size");
            fail_count++;
        end

    // offset is registered together with op_done
    a_offset_hold: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(offset) |-> op_done)
        else begin
            $error("offset changed outside an op_done cycle");
            fail_count++;
        end

endmodule

bind jvm_exec_top jvm_exec_assertions jvm_exec_assertions_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .op_done     (op_done),
    .offset      (offset),
    .stack_depth (stack_depth)
);

// ==== rtl/jvm_exec_top.sv ====
`timescale 1ns/1ps

module jvm_exec_top (
    input  logic             clk,
    input  logic             rst_n,
    input  jvm_pkg::byte_t   op_code,
    input  jvm_pkg::byte_t   arg1,
    input  jvm_pkg::byte_t   arg2,
    output logic             op_done,
    output jvm_pkg::offset_t offset,
    output jvm_pkg::word_t   tos,
    output jvm_pkg::depth_t  stack_depth
);
    import jvm_pkg::*;

    logic     stack_trigger;
    logic     stack_push;
    logic     stack_done;
    word_t    stack_wdata;
    word_t    stack_rdata;
    logic     lva_trigger;
    logic     lva_write;
    logic     lva_done;
    lva_idx_t lva_index;
    word_t    lva_wdata;
    word_t    lva_rdata;
    word_t    operand_a;
    word_t    operand_b;
    word_t    alu_result;
    alu_op_t  alu_op;
    cmp_t     cmp_type;
    logic     is_cmp_two;
    logic     cmp_true;

    exec_control exec_control_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .op_code       (op_code),
        .arg1          (arg1),
        .arg2          (arg2),
        .stack_done    (stack_done),
        .stack_rdata   (stack_rdata),
        .lva_rdata     (lva_rdata),
        .alu_result    (alu_result),
        .cmp_true      (cmp_true),
        .lva_done      (lva_done),
        .stack_trigger (stack_trigger),
        .stack_push    (stack_push),
        .stack_wdata   (stack_wdata),
        .lva_trigger   (lva_trigger),
        .lva_write     (lva_write),
        .lva_index     (lva_index),
        .lva_wdata     (lva_wdata),
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .alu_op        (alu_op),
        .cmp_type      (cmp_type),
        .is_cmp_two    (is_cmp_two),
        .op_done       (op_done),
        .offset        (offset)
    );

    int_alu int_alu_inst (
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .alu_op     (alu_op),
        .cmp_type   (cmp_type),
        .is_cmp_two (is_cmp_two),
        .result     (alu_result),
        .cmp_true   (cmp_true)
    );

    eval_stack eval_stack_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .trigger (stack_trigger),
        .push    (stack_push),
        .wdata   (stack_wdata),
        .done    (stack_done),
        .rdata   (stack_rdata),
        .tos     (tos),
        .depth   (stack_depth)
    );

    local_var_array local_var_array_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .trigger (lva_trigger),
        .write   (lva_write),
        .index   (lva_index),
        .wdata   (lva_wdata),
        .done    (lva_done),
        .rdata   (lva_rdata)
    );

endmodule

// ==== rtl/exec_control.sv ====
`timescale 1ns/1ps
`include "jvm_consts.svh"

module exec_control (
    input  logic              clk,
    input  logic              rst_n,
    input  jvm_pkg::byte_t    op_code,
    input  jvm_pkg::byte_t    arg1,
    input  jvm_pkg::byte_t    arg2,
    input  logic              stack_done,
    input  jvm_pkg::word_t    stack_rdata,
    input  jvm_pkg::word_t    lva_rdata,
    input  jvm_pkg::word_t    alu_result,
    input  logic              cmp_true,
    input  logic              lva_done,
    output logic              stack_trigger,
    output logic              stack_push,     // high push, low pop
    output jvm_pkg::word_t    stack_wdata,
    output logic              lva_trigger,
    output logic              lva_write,      // high write, low read
    output jvm_pkg::lva_idx_t lva_index,
    output jvm_pkg::word_t    lva_wdata,
    output jvm_pkg::word_t    operand_a,
    output jvm_pkg::word_t    operand_b,
    output jvm_pkg::alu_op_t  alu_op,
    output jvm_pkg::cmp_t     cmp_type,
    output logic              is_cmp_two,
    output logic              op_done,
    output jvm_pkg::offset_t  offset
);
    import jvm_pkg::*;

    exec_state_t state;
    logic [1:0]  fetch_wait;      // cycles left before op_code is sampled
    logic [1:0]  pop_cnt;         // pops still to do
    logic        jump;
    logic        finish;          // instruction completes this cycle
    logic        idle_op;
    word_t       wb_value;
    offset_t     next_offset;

    logic        is_alu;
    logic        is_cmp;
    logic        is_const;
    logic        is_arg_push;
    logic        is_goto;
    logic        is_lva_read;
    logic        is_lva_write;
    logic        stack_wb;
    word_t       const_val;
    lva_idx_t    dec_lva_index;
    logic [1:0]  argc;
    logic [1:0]  stack_args;

    bytecode_decoder bytecode_decoder_inst (
        .op_code      (op_code),
        .is_alu       (is_alu),
        .is_cmp       (is_cmp),
        .is_cmp_two   (is_cmp_two),
        .is_const     (is_const),
        .is_arg_push  (is_arg_push),
        .is_goto      (is_goto),
        .is_lva_read  (is_lva_read),
        .is_lva_write (is_lva_write),
        .stack_wb     (stack_wb),
        .alu_op       (alu_op),
        .cmp_type     (cmp_type),
        .const_val    (const_val),
        .lva_index    (dec_lva_index),
        .argc         (argc),
        .stack_args   (stack_args)
    );

    assign idle_op = (op_code == `OP_NOP) || (op_code == `OP_RETURN) ||
                     (op_code == `OP_IRETURN);
    assign finish  = (state == EXEC && !stack_wb) || (state == WRITE && stack_done);
    assign next_offset = jump ? offset_t'({arg1, arg2}) : offset_t'(argc) + offset_t'(1);

    always_comb begin
        if (is_const)
            wb_value = const_val;
        else if (is_arg_push && argc == 2'd1)
            wb_value = {{24{arg1[7]}}, arg1};              // bipush
        else if (is_arg_push)
            wb_value = {{16{arg1[7]}}, arg1, arg2};        // sipush
        else if (is_alu)
            wb_value = alu_result;
        else
            wb_value = lva_rdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            fetch_wait    <= 2'(`JVM_FETCH_WAIT);
            pop_cnt       <= 2'd0;
            jump          <= 1'b0;
            stack_trigger <= 1'b0;
            stack_push    <= 1'b0;
            lva_trigger   <= 1'b0;
            lva_write     <= 1'b0;
            op_done       <= 1'b0;
            offset        <= '0;
        end else begin
            op_done       <= finish;
            stack_trigger <= 1'b0;    // strobes are re-armed below
            lva_trigger   <= 1'b0;
            if (finish) begin
                offset     <= next_offset;
                fetch_wait <= 2'(`JVM_FETCH_WAIT);
                state      <= IDLE;
            end
            case (state)
                IDLE: begin
                    if (fetch_wait != 2'd0)
                        fetch_wait <= fetch_wait - 2'd1;
                    else if (!idle_op)
                        state <= FETCH;
                end
                FETCH: begin
                    pop_cnt <= stack_args;
                    jump    <= 1'b0;
                    state   <= DECODE;
                end
                DECODE: begin
                    if (stack_args != 2'd0) begin
                        stack_trigger <= 1'b1;
                        stack_push    <= 1'b0;
                        state         <= S_LOAD;
                    end else if (is_lva_read) begin
                        state <= LVA_START;
                    end else begin
                        jump  <= is_goto;
                        state <= EXEC;
                    end
                end
                S_LOAD: begin
                    if (stack_done) begin
                        if (pop_cnt == 2'd2) begin
                            pop_cnt       <= pop_cnt - 2'd1;
                            stack_trigger <= 1'b1;    // second pop
                        end else if (is_cmp) begin
                            state <= COMP;
                        end else if (is_lva_write) begin
                            state <= LVA_START;
                        end else begin
                            state <= EXEC;
                        end
                    end
                end
                LVA_START: begin
                    lva_trigger <= 1'b1;
                    lva_write   <= is_lva_write;
                    state       <= LVA_WAIT;
                end
                LVA_WAIT: begin
                    if (lva_done)
                        state <= EXEC;
                end
                COMP: begin
                    jump  <= cmp_true;
                    state <= EXEC;
                end
                EXEC: begin
                    if (stack_wb) begin
                        stack_trigger <= 1'b1;
                        stack_push    <= 1'b1;
                        state         <= WRITE;
                    end
                end
                WRITE: begin
                end
                default: state <= IDLE;
            endcase
        end
    end

    // operands and memory data
    always_ff @(posedge clk) begin
        if (state == DECODE)
            lva_index <= (argc == 2'd1) ? arg1[3:0] : dec_lva_index;
        if (state == S_LOAD && stack_done) begin
            if (pop_cnt == 2'd2)
                operand_b <= stack_rdata;    // top of stack comes first
            else
                operand_a <= stack_rdata;
        end
        if (state == LVA_START)
            lva_wdata <= operand_a;
        if (state == EXEC)
            stack_wdata <= wb_value;
    end

endmodule

// ==== storage/local_var_array.sv ====
`timescale 1ns/1ps
`include "jvm_consts.svh"

module local_var_array (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              trigger,
    input  logic              write,    // high write, low read
    input  jvm_pkg::lva_idx_t index,
    input  jvm_pkg::word_t    wdata,
    output logic              done,
    output jvm_pkg::word_t    rdata
);
    import jvm_pkg::*;

    word_t mem [`JVM_LVA_SIZE];

    // locals start at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
            for (int i = 0; i < `JVM_LVA_SIZE; i++)
                mem[i] <= '0;
        end else begin
            done <= trigger;
            if (trigger && write)
                mem[index] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (trigger && !write)
            rdata <= mem[index];   // valid with done
    end

endmodule

// ==== storage/eval_stack.sv ====
`timescale 1ns/1ps
`include "jvm_consts.svh"

module eval_stack (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            trigger,
    input  logic            push,      // high push, low pop
    input  jvm_pkg::word_t  wdata,
    output logic            done,
    output jvm_pkg::word_t  rdata,     // popped value that is held until the next pop
    output jvm_pkg::word_t  tos,
    output jvm_pkg::depth_t depth
);
    import jvm_pkg::*;

    word_t      mem [`JVM_STACK_DEPTH];
    depth_t     sp;                    // filled entries
    logic [3:0] top_idx;
    logic       empty;
    logic       full;

    assign empty   = (sp == '0);
    assign full    = (sp == depth_t'(`JVM_STACK_DEPTH));
    assign top_idx = 4'(sp - depth_t'(1));
    assign tos     = empty ? '0 : mem[top_idx];
    assign depth   = sp;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sp   <= '0;
            done <= 1'b0;
        end else begin
            done <= trigger;
            if (trigger && push && !full)
                sp <= sp + depth_t'(1);
            else if (trigger && !push && !empty)
                sp <= sp - depth_t'(1);
        end
    end

    // a push to a full stack is dropped and a pop from empty reads 0
    always_ff @(posedge clk) begin
        if (trigger && push && !full)
            mem[sp[3:0]] <= wdata;
        if (trigger && !push)
            rdata <= empty ? '0 : mem[top_idx];
    end

endmodule

// ==== rtl/int_alu.sv ====
`timescale 1ns/1ps

module int_alu (
    input  jvm_pkg::word_t   operand_a,   // deeper stack value
    input  jvm_pkg::word_t   operand_b,   // top stack value
    input  jvm_pkg::alu_op_t alu_op,
    input  jvm_pkg::cmp_t    cmp_type,
    input  logic             is_cmp_two,
    output jvm_pkg::word_t   result,
    output logic             cmp_true
);
    import jvm_pkg::*;

    logic [4:0] shamt;
    word_t      rhs;                      // right side of the comparison

    assign shamt = operand_b[4:0];
    assign rhs   = is_cmp_two ? operand_b : '0;

    always_comb begin
        case (alu_op)
            ALU_ADD: result = operand_a + operand_b;
            ALU_SUB: result = operand_a - operand_b;
            ALU_MUL: result = operand_a * operand_b;     // low word only
            ALU_AND: result = operand_a & operand_b;
            ALU_OR:  result = operand_a | operand_b;
            ALU_XOR: result = operand_a ^ operand_b;
            ALU_SHL: result = operand_a << shamt;
            ALU_SHR: result = word_t'($signed(operand_a) >>> shamt);
            default: result = '0;
        endcase
    end

    // JVM branch compares are signed
    always_comb begin
        case (cmp_type)
            EQ:      cmp_true = (operand_a == rhs);
            NE:      cmp_true = (operand_a != rhs);
            LT:      cmp_true = ($signed(operand_a) <  $signed(rhs));
            LE:      cmp_true = ($signed(operand_a) <= $signed(rhs));
            GE:      cmp_true = ($signed(operand_a) >= $signed(rhs));
            GT:      cmp_true = ($signed(operand_a) >  $signed(rhs));
            default: cmp_true = 1'b0;
        endcase
    end

endmodule

// ==== rtl/bytecode_decoder.sv ====
`timescale 1ns/1ps
`include "jvm_consts.svh"

module bytecode_decoder (
    input  jvm_pkg::byte_t    op_code,
    output logic              is_alu,
    output logic              is_cmp,
    output logic              is_cmp_two,    // if_icmp form that compares two stack values
    output logic              is_const,
    output logic              is_arg_push,   // bipush or sipush
    output logic              is_goto,
    output logic              is_lva_read,
    output logic              is_lva_write,
    output logic              stack_wb,      // result is pushed back
    output jvm_pkg::alu_op_t  alu_op,
    output jvm_pkg::cmp_t     cmp_type,
    output jvm_pkg::word_t    const_val,
    output jvm_pkg::lva_idx_t lva_index,     // implied index of the short forms
    output logic [1:0]        argc,          // inline argument bytes
    output logic [1:0]        stack_args     // values popped before execution
);
    import jvm_pkg::*;

    always_comb begin
        is_alu       = 1'b0;
        is_cmp       = 1'b0;
        is_cmp_two   = 1'b0;
        is_const     = 1'b0;
        is_arg_push  = 1'b0;
        is_goto      = 1'b0;
        is_lva_read  = 1'b0;
        is_lva_write = 1'b0;
        stack_wb     = 1'b0;
        alu_op       = ALU_ADD;
        cmp_type     = EQ;
        const_val    = '0;
        lva_index    = '0;
        argc         = 2'd0;
        stack_args   = 2'd0;
        case (op_code)
            `OP_ICONST_M1, `OP_ICONST_0, `OP_ICONST_1, `OP_ICONST_2,
            `OP_ICONST_3, `OP_ICONST_4, `OP_ICONST_5: begin
                is_const  = 1'b1;
                stack_wb  = 1'b1;
                const_val = word_t'(op_code) - word_t'(3); // 0x02 gives -1
            end
            `OP_BIPUSH, `OP_SIPUSH: begin
                is_arg_push = 1'b1;
                stack_wb    = 1'b1;
                argc        = (op_code == `OP_SIPUSH) ? 2'd2 : 2'd1;
            end
            `OP_ILOAD: begin
                is_lva_read = 1'b1;
                stack_wb    = 1'b1;
                argc        = 2'd1;
            end
            `OP_ILOAD_0, `OP_ILOAD_1, `OP_ILOAD_2, `OP_ILOAD_3: begin
                is_lva_read = 1'b1;
                stack_wb    = 1'b1;
                lva_index   = lva_idx_t'(op_code - `OP_ILOAD_0);
            end
            `OP_ISTORE: begin
                is_lva_write = 1'b1;
                stack_args   = 2'd1;
                argc         = 2'd1;
            end
            `OP_ISTORE_0, `OP_ISTORE_1, `OP_ISTORE_2, `OP_ISTORE_3: begin
                is_lva_write = 1'b1;
                stack_args   = 2'd1;
                lva_index    = lva_idx_t'(op_code - `OP_ISTORE_0);
            end
            `OP_IADD, `OP_ISUB, `OP_IMUL, `OP_ISHL,
            `OP_ISHR, `OP_IAND, `OP_IOR, `OP_IXOR: begin
                is_alu     = 1'b1;
                stack_wb   = 1'b1;
                stack_args = 2'd2;
                case (op_code)
                    `OP_ISUB: alu_op = ALU_SUB;
                    `OP_IMUL: alu_op = ALU_MUL;
                    `OP_ISHL: alu_op = ALU_SHL;
                    `OP_ISHR: alu_op = ALU_SHR;
                    `OP_IAND: alu_op = ALU_AND;
                    `OP_IOR:  alu_op = ALU_OR;
                    `OP_IXOR: alu_op = ALU_XOR;
                    default:  alu_op = ALU_ADD;
                endcase
            end
            `OP_IFEQ, `OP_IFNE, `OP_IFLT, `OP_IFGE, `OP_IFGT, `OP_IFLE,
            `OP_IF_ICMPEQ, `OP_IF_ICMPNE, `OP_IF_ICMPLT,
            `OP_IF_ICMPGE, `OP_IF_ICMPGT, `OP_IF_ICMPLE: begin
                is_cmp     = 1'b1;
                is_cmp_two = (op_code >= `OP_IF_ICMPEQ);
                stack_args = (op_code >= `OP_IF_ICMPEQ) ? 2'd2 : 2'd1;
                argc       = 2'd2;               // branch offset bytes
                case (op_code)
                    `OP_IFNE, `OP_IF_ICMPNE: cmp_type = NE;
                    `OP_IFLT, `OP_IF_ICMPLT: cmp_type = LT;
                    `OP_IFGE, `OP_IF_ICMPGE: cmp_type = GE;
                    `OP_IFGT, `OP_IF_ICMPGT: cmp_type = GT;
                    `OP_IFLE, `OP_IF_ICMPLE: cmp_type = LE;
                    default:                 cmp_type = EQ;
                endcase
            end
            `OP_GOTO: begin
                is_goto = 1'b1;
                argc    = 2'd2;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== common/jvm_pkg.sv ====
`include "jvm_consts.svh"

package jvm_pkg;

    typedef logic [`JVM_WORD_W-1:0] word_t;    // stack entry or local value
    typedef logic [7:0]             byte_t;    // opcode or argument byte
    typedef logic signed [15:0]     offset_t;  // distance to next instruction
    typedef logic [3:0]             lva_idx_t;
    typedef logic [4:0]             depth_t;   // stack fill count from 0 to 16

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_MUL, ALU_AND,
        ALU_OR, ALU_XOR, ALU_SHL, ALU_SHR
    } alu_op_t;

    typedef enum logic [2:0] {
        EQ, NE, LT, LE, GE, GT
    } cmp_t;

    typedef enum logic [3:0] {
        IDLE, FETCH, DECODE, S_LOAD, LVA_START,
        LVA_WAIT, COMP, EXEC, WRITE
    } exec_state_t;

endpackage

// ==== common/jvm_consts.svh ====
`ifndef JVM_CONSTS_SVH
`define JVM_CONSTS_SVH

`define JVM_WORD_W      32
`define JVM_STACK_DEPTH 16
`define JVM_LVA_SIZE    16
`define JVM_FETCH_WAIT  3  // idle cycles before op_code is sampled

// opcodes in JVM encoding
`define OP_NOP       8'h00
`define OP_ICONST_M1 8'h02
`define OP_ICONST_0  8'h03
`define OP_ICONST_1  8'h04
`define OP_ICONST_2  8'h05
`define OP_ICONST_3  8'h06
`define OP_ICONST_4  8'h07
`define OP_ICONST_5  8'h08
`define OP_BIPUSH    8'h10
`define OP_SIPUSH    8'h11
`define OP_ILOAD     8'h15
`define OP_ILOAD_0   8'h1a
`define OP_ILOAD_1   8'h1b
`define OP_ILOAD_2   8'h1c
`define OP_ILOAD_3   8'h1d
`define OP_ISTORE    8'h36
`define OP_ISTORE_0  8'h3b
`define OP_ISTORE_1  8'h3c
`define OP_ISTORE_2  8'h3d
`define OP_ISTORE_3  8'h3e
`define OP_IADD      8'h60
`define OP_ISUB      8'h64
`define OP_IMUL      8'h68
`define OP_ISHL      8'h78
`define OP_ISHR      8'h7a
`define OP_IAND      8'h7e
`define OP_IOR       8'h80
`define OP_IXOR      8'h82
`define OP_IFEQ      8'h99
`define OP_IFNE      8'h9a
`define OP_IFLT      8'h9b
`define OP_IFGE      8'h9c
`define OP_IFGT      8'h9d
`define OP_IFLE      8'h9e
`define OP_IF_ICMPEQ 8'h9f
`define OP_IF_ICMPNE 8'ha0
`define OP_IF_ICMPLT 8'ha1
`define OP_IF_ICMPGE 8'ha2
`define OP_IF_ICMPGT 8'ha3
`define OP_IF_ICMPLE 8'ha4
`define OP_GOTO      8'ha7
`define OP_IRETURN   8'hac
`define OP_RETURN    8'hb1

`endif
